// ==== Makefile ====
SRCS := $(shell cat vlog.f)

obj_dir/Vmem_arb_tb: vlog.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module mem_arb_tb -f vlog.f -o Vmem_arb_tb

run: obj_dir/Vmem_arb_tb
	@out="$$(./obj_dir/Vmem_arb_tb)"; echo "$$out"; echo "$$out" | grep -qx 'all tests passed'

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== source/mem_arb_ctl.sv ====
// ********************
// Arbiter control: round-robin pointer, credits, stalls and issue.
// ********************
`default_nettype none

module mem_arb_ctl #(
	parameter int CLIENTS         = 2,
	parameter int CREDITS_DEFAULT = 1
) (
	input  wire logic               clkrst_mem_clk,
	input  wire logic               clkrst_mem_rst_n,
	input  wire logic [CLIENTS-1:0] cli_valid,
	input  wire logic               ltc_stall,
	arb_sel_if.ctl                  sel,
	tag_if.wr                       tag,
	output logic                    ltc_valid,
	output logic [CLIENTS-1:0]      cli_stall
);

	localparam int CLI_W = (CLIENTS > 1) ? $clog2(CLIENTS) : 1;
	localparam int CRED_W = (CREDITS_DEFAULT > 0) ? $clog2(CREDITS_DEFAULT + 1) : 1;

	logic [CLI_W-1:0]  cur_q;
	logic [CLI_W-1:0]  next_client;
	logic [CRED_W-1:0] credits_q;
	logic              rd_wait;
	logic              accept;

	// ********************
	// next client search
	// ********************

	// scan the clients after the current one in rotation order. The
	// first valid one wins, otherwise the pointer stays where it is.
	always_comb begin
		int unsigned idx;
		logic        found;
		next_client = cur_q;
		found = 1'b0;
		for (int i = 1; i < CLIENTS; i++) begin
			idx = (int'(cur_q) + i) % CLIENTS;
			if (!found && cli_valid[idx]) begin
				next_client = CLI_W'(idx);
				found = 1'b1;
			end
		end
	end

	// a read with no free tag slot is held back. It costs no credit.
	assign rd_wait = sel.sel_valid && sel.sel_has_rdata && tag.full;
	assign ltc_valid = sel.sel_valid && !rd_wait;
	assign accept = ltc_valid && !ltc_stall;

	assign tag.push = accept && sel.sel_has_rdata;
	assign tag.wtag = cur_q;
	assign sel.cur_client = cur_q;

	// nothing moves while the LTC stalls, so ltc_req stays stable.
	always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
		if (!clkrst_mem_rst_n) begin
			cur_q <= '0;
			credits_q <= CRED_W'(CREDITS_DEFAULT);
		end else if (!ltc_stall) begin
			if (!sel.sel_valid || (accept && (credits_q == '0))) begin
				cur_q <= next_client;
				credits_q <= CRED_W'(CREDITS_DEFAULT);
			end else if (accept) begin
				credits_q <= credits_q - 1'b1;
			end
		end
	end

	// ********************
	// client stalls
	// ********************

	always_comb begin
		for (int c = 0; c < CLIENTS; c++) begin
			cli_stall[c] = cli_valid[c] &&
				((int'(cur_q) != c) || ltc_stall || rd_wait);
		end
	end

endmodule

`default_nettype wire

// ==== source/mem_arb_ifs.sv ====
// ********************
// Internal bundles of the arbiter: client selection and read tag queue.
// ********************
`default_nettype none

// selection bundle between the control FSM and the request mux.
interface arb_sel_if import mem_arb_pkg::*; #(
	parameter int CLIENTS = 2
) ();
	localparam int CLI_W = (CLIENTS > 1) ? $clog2(CLIENTS) : 1;

	logic [CLI_W-1:0] cur_client;
	logic             sel_valid;
	logic             sel_has_rdata;
	ltc_req_t         sel_req;

	modport ctl (output cur_client, input sel_valid, input sel_has_rdata);
	modport mux (input cur_client, output sel_valid, output sel_has_rdata, output sel_req);
endinterface

// push side from control, pop side from the return path.
interface tag_if #(
	parameter int CLIENTS = 2
) ();
	localparam int CLI_W = (CLIENTS > 1) ? $clog2(CLIENTS) : 1;

	logic             push;
	logic [CLI_W-1:0] wtag;
	logic             full;
	logic             pop;
	logic [CLI_W-1:0] rtag;
	logic             empty;

	modport wr (output push, output wtag, input full);
	modport rd (output pop, input rtag, input empty);
	modport fifo (input push, input wtag, input pop, output full, output rtag, output empty);
endinterface

`default_nettype wire

// ==== source/mem_arb_pkg.sv ====
// ********************
// Shared types and widths for the LTC request arbiter.
// Imported by every design module that handles a request or a cache line.
// ********************
`default_nettype none

package mem_arb_pkg;

	// cache line geometry seen on the LTC port.
	localparam int LINE_W = 256;
	localparam int LINE_ADDR_W = 27;
	localparam int WBE_W = 32;

	typedef enum logic [2:0] {
		LTC_OPC_READ         = 3'b000,
		LTC_OPC_WRITE        = 3'b001,
		LTC_OPC_READTHROUGH  = 3'b100,
		LTC_OPC_WRITETHROUGH = 3'b101,
		LTC_OPC_PREFETCH     = 3'b110
	} ltc_opc_t;

	// addr holds byte address bits 31 to 5.
	typedef struct packed {
		ltc_opc_t               opc;
		logic [LINE_ADDR_W-1:0] addr;
		logic [LINE_W-1:0]      wdata;
		logic [WBE_W-1:0]       wbe;
	} ltc_req_t;

	// only the two read flavors produce a return on ltc_rdata.
	function automatic logic opc_has_rdata(input ltc_opc_t opc);
		return (opc == LTC_OPC_READ) || (opc == LTC_OPC_READTHROUGH);
	endfunction

endpackage

`default_nettype wire

// ==== source/mem_arb_top.sv ====
// ********************
// LTC request arbiter top level with plain client and LTC ports.
// ********************
`default_nettype none

module mem_arb_top import mem_arb_pkg::*; #(
	parameter int CLIENTS         = 2,
	parameter int CREDITS_DEFAULT = 1,
	parameter int TAG_DEPTH       = 4
) (
	input  wire logic                   clkrst_mem_clk,
	input  wire logic                   clkrst_mem_rst_n,

	// client side
	input  wire logic [CLIENTS-1:0]     cli_valid,
	input  wire ltc_req_t [CLIENTS-1:0] cli_req,
	output logic [CLIENTS-1:0]          cli_stall,
	output logic [CLIENTS-1:0]          cli_rvalid,
	output logic [LINE_W-1:0]           cli_rdata,

	// cache controller side
	output logic                        ltc_valid,
	output ltc_req_t                    ltc_req,
	input  wire logic                   ltc_stall,
	input  wire logic                   ltc_rvalid,
	input  wire logic [LINE_W-1:0]      ltc_rdata
);

	arb_sel_if #(.CLIENTS(CLIENTS)) sel_bus ();
	tag_if #(.CLIENTS(CLIENTS)) tag_bus ();

	mem_arb_ctl #(
		.CLIENTS(CLIENTS),
		.CREDITS_DEFAULT(CREDITS_DEFAULT)
	) ctl0 (
		.clkrst_mem_clk(clkrst_mem_clk),
		.clkrst_mem_rst_n(clkrst_mem_rst_n),
		.cli_valid(cli_valid),
		.ltc_stall(ltc_stall),
		.sel(sel_bus.ctl),
		.tag(tag_bus.wr),
		.ltc_valid(ltc_valid),
		.cli_stall(cli_stall)
	);

	mem_req_mux #(.CLIENTS(CLIENTS)) mux0 (
		.cli_req(cli_req),
		.cli_valid(cli_valid),
		.sel(sel_bus.mux),
		.ltc_req(ltc_req)
	);

	mem_rd_tag_fifo #(
		.CLIENTS(CLIENTS),
		.TAG_DEPTH(TAG_DEPTH)
	) tagq0 (
		.clkrst_mem_clk(clkrst_mem_clk),
		.clkrst_mem_rst_n(clkrst_mem_rst_n),
		.tag(tag_bus.fifo)
	);

	mem_rd_return #(.CLIENTS(CLIENTS)) ret0 (
		.clkrst_mem_clk(clkrst_mem_clk),
		.clkrst_mem_rst_n(clkrst_mem_rst_n),
		.ltc_rvalid(ltc_rvalid),
		.ltc_rdata(ltc_rdata),
		.tag(tag_bus.rd),
		.cli_rvalid(cli_rvalid),
		.cli_rdata(cli_rdata)
	);

endmodule

`default_nettype wire

// ==== source/mem_rd_return.sv ====
// ********************
// Registers LTC read returns and steers them to the owning client.
// ********************
`default_nettype none

module mem_rd_return import mem_arb_pkg::*; #(
	parameter int CLIENTS = 2
) (
	input  wire logic              clkrst_mem_clk,
	input  wire logic              clkrst_mem_rst_n,
	input  wire logic              ltc_rvalid,
	input  wire logic [LINE_W-1:0] ltc_rdata,
	tag_if.rd                      tag,
	output logic [CLIENTS-1:0]     cli_rvalid,
	output logic [LINE_W-1:0]      cli_rdata
);

	localparam int CLI_W = (CLIENTS > 1) ? $clog2(CLIENTS) : 1;

	logic              rvalid_q;
	logic [CLI_W-1:0]  tag_q;
	logic [LINE_W-1:0] rdata_q;

	// returns come back in issue order, so the head tag owns this one.
	assign tag.pop = ltc_rvalid && !tag.empty;

	always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
		if (!clkrst_mem_rst_n) begin
			rvalid_q <= 1'b0;
			tag_q <= '0;
		end else begin
			rvalid_q <= ltc_rvalid;
			if (ltc_rvalid) begin
				tag_q <= tag.rtag;
			end
		end
	end

	always_ff @(posedge clkrst_mem_clk) begin
		if (ltc_rvalid) begin
			rdata_q <= ltc_rdata;
		end
	end

	// one shared data bus. Only the owner sees rvalid.
	always_comb begin
		for (int c = 0; c < CLIENTS; c++) begin
			cli_rvalid[c] = rvalid_q && (int'(tag_q) == c);
		end
	end

	assign cli_rdata = rdata_q;

endmodule

`default_nettype wire

// ==== source/mem_rd_tag_fifo.sv ====
// ********************
// Queue of client numbers for reads still waiting on an LTC return.
// ********************
`default_nettype none

module mem_rd_tag_fifo #(
	parameter int CLIENTS   = 2,
	parameter int TAG_DEPTH = 4
) (
	input  wire logic clkrst_mem_clk,
	input  wire logic clkrst_mem_rst_n,
	tag_if.fifo       tag
);

	localparam int CLI_W = (CLIENTS > 1) ? $clog2(CLIENTS) : 1;
	localparam int PTR_W = (TAG_DEPTH > 1) ? $clog2(TAG_DEPTH) : 1;
	localparam int CNT_W = $clog2(TAG_DEPTH + 1);

	logic [CLI_W-1:0] mem [TAG_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	assign tag.full = (count == CNT_W'(TAG_DEPTH));
	assign tag.empty = (count == '0);
	assign tag.rtag = mem[rd_ptr];

	// each push writes its client number at the write pointer.
	always_ff @(posedge clkrst_mem_clk) begin
		if (tag.push) begin
			mem[wr_ptr] <= tag.wtag;
		end
	end

	always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
		if (!clkrst_mem_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (tag.push) begin
				wr_ptr <= (wr_ptr == PTR_W'(TAG_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (tag.pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(TAG_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// a push and a pop in the same cycle leave the count alone.
			if (tag.push && !tag.pop) begin
				count <= count + 1'b1;
			end else if (tag.pop && !tag.push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/mem_req_mux.sv ====
// ********************
// Routes the current client's request to the LTC port.
// ********************
`default_nettype none

module mem_req_mux import mem_arb_pkg::*; #(
	parameter int CLIENTS = 2
) (
	input  wire ltc_req_t [CLIENTS-1:0] cli_req,
	input  wire logic [CLIENTS-1:0]     cli_valid,
	arb_sel_if.mux                      sel,
	output ltc_req_t                    ltc_req
);

	// the pointer never exceeds CLIENTS-1, so the index stays in range.
	assign sel.sel_valid = cli_valid[sel.cur_client];
	assign sel.sel_req = cli_req[sel.cur_client];

	// control needs this to decide whether a tag slot is required.
	assign sel.sel_has_rdata = opc_has_rdata(sel.sel_req.opc);

	assign ltc_req = sel.sel_req;

endmodule

`default_nettype wire

// ==== tb/ltc_model.sv ====
// ********************
// Behavioral LTC with a 64-line memory and in-order read returns.
// The testbench holds ltc_stall or withholds returns through hold_stall and hold_ret.
// ********************
`default_nettype none

module ltc_model import mem_arb_pkg::*; #(
	parameter int LATENCY = 3
) (
	input  wire logic              clkrst_mem_clk,
	input  wire logic              ltc_valid,
	input  wire ltc_req_t          ltc_req,
	input  wire logic              hold_stall,
	input  wire logic              hold_ret,
	output logic                   ltc_stall,
	output logic                   ltc_rvalid,
	output logic [LINE_W-1:0]      ltc_rdata
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [LINE_W-1:0] mem [64];
	logic [LINE_W-1:0] ret_data [$];
	int                ret_due [$];
	int                cycle;

	assign ltc_stall = hold_stall;

	// every 32-bit word carries its line index and word number.
	initial begin
		cycle = 0;
		ltc_rvalid = 1'b0;
		ltc_rdata = '0;
		for (int i = 0; i < 64; i++) begin
			for (int w = 0; w < LINE_W / 32; w++) begin
				mem[i][32*w +: 32] = 32'hc300_0000 | (32'(i) << 8) | 32'(w);
			end
		end
	end

	always @(posedge clkrst_mem_clk) begin
		logic [5:0] idx;
		cycle++;
		ltc_rvalid <= 1'b0;
		if (!hold_ret && (ret_due.size() > 0) && (ret_due[0] <= cycle)) begin
			ltc_rvalid <= 1'b1;
			ltc_rdata <= ret_data.pop_front();
			void'(ret_due.pop_front());
		end
		if (ltc_valid && !ltc_stall) begin
			idx = ltc_req.addr[5:0];
			if ((ltc_req.opc == LTC_OPC_READ) || (ltc_req.opc == LTC_OPC_READTHROUGH)) begin
				ret_data.push_back(mem[idx]);
				ret_due.push_back(cycle + LATENCY);
			end else if ((ltc_req.opc == LTC_OPC_WRITE) || (ltc_req.opc == LTC_OPC_WRITETHROUGH)) begin
				for (int b = 0; b < WBE_W; b++) begin
					if (ltc_req.wbe[b]) begin
						mem[idx][8*b +: 8] = ltc_req.wdata[8*b +: 8];
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb/mem_arb_tb.sv ====
// ********************
// Directed testbench for the LTC request arbiter, run against ltc_model.
// ********************
`default_nettype none

module mem_arb_tb import mem_arb_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLIENTS = 2;
	localparam int CREDITS = 1;
	localparam int DEPTH = 4;
	localparam int LIMIT = 300;

	logic                   clkrst_mem_clk = 1'b0;
	logic                   clkrst_mem_rst_n;
	logic [CLIENTS-1:0]     cli_valid;
	ltc_req_t [CLIENTS-1:0] cli_req;
	logic [CLIENTS-1:0]     cli_stall;
	logic [CLIENTS-1:0]     cli_rvalid;
	logic [LINE_W-1:0]      cli_rdata;
	logic                   ltc_valid;
	ltc_req_t               ltc_req;
	logic                   ltc_stall;
	logic                   ltc_rvalid;
	logic [LINE_W-1:0]      ltc_rdata;
	logic                   hold_stall;
	logic                   hold_ret;

	// per-client request queues. The head is what the client presents.
	ltc_req_t          cq [CLIENTS][$];
	logic [CLIENTS-1:0] adv;
	int                acc_client [$];
	int                acc_cycle [$];
	int                exp_owner [$];
	logic [LINE_W-1:0] exp_data [$];
	logic [LINE_W-1:0] shadow [64];
	logic              rv_prev = 1'b0;
	int                cycle = 0;
	int                rets = 0;
	int                errors = 0;
	integer            seed = 32'h6e8d;

	always #5 clkrst_mem_clk = ~clkrst_mem_clk;

	// cycle number, counted on the rising edge and read at the negative edge.
	always @(posedge clkrst_mem_clk) begin
		cycle++;
	end

	mem_arb_top #(
		.CLIENTS(CLIENTS),
		.CREDITS_DEFAULT(CREDITS),
		.TAG_DEPTH(DEPTH)
	) dut0 (
		.clkrst_mem_clk(clkrst_mem_clk),
		.clkrst_mem_rst_n(clkrst_mem_rst_n),
		.cli_valid(cli_valid),
		.cli_req(cli_req),
		.cli_stall(cli_stall),
		.cli_rvalid(cli_rvalid),
		.cli_rdata(cli_rdata),
		.ltc_valid(ltc_valid),
		.ltc_req(ltc_req),
		.ltc_stall(ltc_stall),
		.ltc_rvalid(ltc_rvalid),
		.ltc_rdata(ltc_rdata)
	);

	ltc_model #(.LATENCY(3)) ltc0 (
		.clkrst_mem_clk(clkrst_mem_clk),
		.ltc_valid(ltc_valid),
		.ltc_req(ltc_req),
		.hold_stall(hold_stall),
		.hold_ret(hold_ret),
		.ltc_stall(ltc_stall),
		.ltc_rvalid(ltc_rvalid),
		.ltc_rdata(ltc_rdata)
	);

	function automatic logic is_read_opc(input ltc_opc_t opc);
		return (opc == LTC_OPC_READ) || (opc == LTC_OPC_READTHROUGH);
	endfunction

	// byte lanes with wbe set take the new data.
	function automatic logic [LINE_W-1:0] merge_line(input logic [LINE_W-1:0] old,
			input ltc_req_t r);
		logic [LINE_W-1:0] res;
		res = old;
		for (int b = 0; b < WBE_W; b++) begin
			if (r.wbe[b]) begin
				res[8*b +: 8] = r.wdata[8*b +: 8];
			end
		end
		return res;
	endfunction

	// ********************
	// compare tasks
	// ********************

	task automatic note(input string what);
		errors++;
		$display("at %0t ns: %s", $time, what);
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t ns %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			errors++;
			$display("ERROR %0t ns %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_client(input string name, input int got, input int exp);
		if (got != exp) begin
			errors++;
			$display("ERROR %0t ns %s got client %0d expected client %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_req(input string name, input ltc_req_t got, input ltc_req_t exp);
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t ns %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_line(input string name, input logic [LINE_W-1:0] got,
			input logic [LINE_W-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t ns %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// ********************
	// client driver and monitor
	// ********************

	always @(posedge clkrst_mem_clk) begin
		#1;
		for (int c = 0; c < CLIENTS; c++) begin
			if (adv[c] && (cq[c].size() > 0)) begin
				void'(cq[c].pop_front());
			end
			cli_valid[c] = (cq[c].size() > 0);
			if (cq[c].size() > 0) begin
				cli_req[c] = cq[c][0];
			end else begin
				cli_req[c] = '0;
			end
		end
	end

	// inputs are stable between the negative edge and the next rising edge.
	always @(negedge clkrst_mem_clk) begin
		int owner;
		owner = 0;
		adv = cli_valid & ~cli_stall;
		if (ltc_valid && !ltc_stall) begin
			if (!$onehot(adv)) begin
				note("request accepted without exactly one advancing client");
			end else begin
				for (int c = 0; c < CLIENTS; c++) begin
					if (adv[c]) begin
						owner = c;
					end
				end
				acc_client.push_back(owner);
				acc_cycle.push_back(cycle);
				check_req("ltc_req", ltc_req, cq[owner][0]);
				if (is_read_opc(ltc_req.opc)) begin
					exp_owner.push_back(owner);
					exp_data.push_back(shadow[ltc_req.addr[5:0]]);
				end else if (ltc_req.opc != LTC_OPC_PREFETCH) begin
					shadow[ltc_req.addr[5:0]] = merge_line(shadow[ltc_req.addr[5:0]], ltc_req);
				end
			end
		end
		check_bit("cli_rvalid one cycle after ltc_rvalid", cli_rvalid != '0, rv_prev);
		if (cli_rvalid != '0) begin
			rets++;
			if (!$onehot(cli_rvalid) || (exp_owner.size() == 0)) begin
				note("read return with several owners or no read outstanding");
			end else begin
				check_client("cli_rvalid", cli_rvalid[1] ? 1 : 0, exp_owner.pop_front());
				check_line("cli_rdata", cli_rdata, exp_data.pop_front());
			end
		end
		rv_prev = ltc_rvalid;
	end

	// ********************
	// helpers and tests
	// ********************

	task automatic timeout(input string what);
		errors++;
		$display("timeout while waiting for %s", what);
		$display("summary: %0d errors", errors);
		$display("tests failed");
		$finish;
	endtask

	task automatic queue_req(input int c, input ltc_opc_t opc, input int line,
			input logic [WBE_W-1:0] wbe);
		ltc_req_t r;
		r.opc = opc;
		r.addr = LINE_ADDR_W'(line);
		for (int w = 0; w < LINE_W / 32; w++) begin
			r.wdata[32*w +: 32] = $random(seed);
		end
		r.wbe = wbe;
		cq[c].push_back(r);
	endtask

	function automatic logic drained();
		return (cq[0].size() == 0) && (cq[1].size() == 0) && (cli_valid == '0)
			&& (exp_owner.size() == 0);
	endfunction

	task automatic wait_drained(input string what);
		for (int t = 0; (t < LIMIT) && !drained(); t++) begin
			@(negedge clkrst_mem_clk);
		end
		if (!drained()) begin
			timeout(what);
		end
	endtask

	task automatic clear_log();
		@(negedge clkrst_mem_clk);
		acc_client.delete();
		acc_cycle.delete();
	endtask

	// runs of CREDITS+1 alternate while both clients still have requests.
	task automatic check_rotation(input int n0, input int n1);
		int pend [2];
		int cur;
		int run;
		pend[0] = n0;
		pend[1] = n1;
		check_count("accepted requests", acc_client.size(), n0 + n1);
		if (acc_client.size() == n0 + n1) begin
			cur = acc_client[0];
			run = 0;
			for (int k = 0; k < n0 + n1; k++) begin
				if ((pend[cur] == 0) || (run == CREDITS + 1)) begin
					if (pend[1 - cur] > 0) begin
						cur = 1 - cur;
					end
					run = 0;
				end
				check_client("granted client", acc_client[k], cur);
				pend[cur]--;
				run++;
			end
		end
	endtask

	task automatic back_to_back();
		for (int k = 1; k < acc_cycle.size(); k++) begin
			if (acc_cycle[k] != acc_cycle[k-1] + 1) begin
				note("accepted requests were not on consecutive cycles");
			end
		end
	endtask

	task automatic reset_idle();
		for (int i = 0; i < 5; i++) begin
			@(negedge clkrst_mem_clk);
			check_bit("ltc_valid", ltc_valid, 1'b0);
			check_bit("cli_stall", |cli_stall, 1'b0);
			check_bit("cli_rvalid", |cli_rvalid, 1'b0);
			if (i == 0) begin
				@(posedge clkrst_mem_clk);
				#1;
				clkrst_mem_rst_n = 1'b1;
			end
		end
		for (int i = 0; i < 64; i++) begin
			shadow[i] = ltc0.mem[i];
		end
	endtask

	task automatic write_then_read();
		int r0;
		@(negedge clkrst_mem_clk);
		r0 = rets;
		queue_req(0, LTC_OPC_WRITE, 5, $random(seed));
		queue_req(0, LTC_OPC_READ, 5, '0);
		wait_drained("write then read");
		check_count("read returns", rets - r0, 1);
	endtask

	task automatic credit_rotation();
		clear_log();
		for (int k = 0; k < 6; k++) begin
			if (k < 2) begin
				queue_req(0, LTC_OPC_WRITE, 40 + k, '1);
			end
			queue_req(1, LTC_OPC_WRITETHROUGH, 50 + k, $random(seed));
		end
		wait_drained("credit rotation");
		check_rotation(2, 6);
		back_to_back();
	endtask

	task automatic back_pressure();
		ltc_req_t held;
		@(posedge clkrst_mem_clk);
		#1;
		hold_stall = 1'b1;
		clear_log();
		for (int k = 0; k < 4; k++) begin
			queue_req(0, LTC_OPC_WRITE, 8 + k, $random(seed));
			queue_req(1, LTC_OPC_WRITE, 16 + k, $random(seed));
		end
		repeat (2) @(negedge clkrst_mem_clk);
		held = ltc_req;
		repeat (4) begin
			@(negedge clkrst_mem_clk);
			check_req("ltc_req under stall", ltc_req, held);
			check_bit("ltc_valid under stall", ltc_valid, 1'b1);
			for (int c = 0; c < CLIENTS; c++) begin
				check_bit($sformatf("cli_stall[%0d] under stall", c), cli_stall[c], 1'b1);
			end
		end
		@(posedge clkrst_mem_clk);
		#1;
		hold_stall = 1'b0;
		wait_drained("back-pressure release");
		check_rotation(4, 4);
		back_to_back();
	endtask

	task automatic full_fifo();
		int rel;
		@(posedge clkrst_mem_clk);
		#1;
		hold_ret = 1'b1;
		clear_log();
		for (int k = 0; k <= DEPTH; k++) begin
			queue_req(0, LTC_OPC_READ, 30 + k, '0);
		end
		for (int t = 0; (t < LIMIT) && (acc_client.size() < DEPTH); t++) begin
			@(negedge clkrst_mem_clk);
		end
		if (acc_client.size() < DEPTH) begin
			timeout("reads to fill the tag FIFO");
		end
		repeat (3) begin
			@(negedge clkrst_mem_clk);
			check_bit("ltc_valid with full tag FIFO", ltc_valid, 1'b0);
			check_bit("cli_stall[0] with full tag FIFO", cli_stall[0], 1'b1);
		end
		check_count("reads accepted while full", acc_client.size(), DEPTH);
		rel = cycle;
		@(posedge clkrst_mem_clk);
		#1;
		hold_ret = 1'b0;
		wait_drained("held read after a return");
		check_count("reads accepted", acc_client.size(), DEPTH + 1);
		// the first return comes two edges after rel and frees its slot on the next edge.
		if (acc_cycle.size() > DEPTH) begin
			check_count("held read issue cycle after release", acc_cycle[DEPTH] - rel, 3);
		end
	endtask

	task automatic interleaved_reads();
		int r0;
		clear_log();
		r0 = rets;
		for (int k = 0; k < 4; k++) begin
			queue_req(0, LTC_OPC_READ, 10 + k, '0);
			queue_req(1, LTC_OPC_READTHROUGH, (k == 0) ? 5 : 20 + k, '0);
		end
		wait_drained("interleaved reads");
		check_count("read returns", rets - r0, 8);
		check_rotation(4, 4);
	endtask

	initial begin
		clkrst_mem_rst_n = 1'b0;
		cli_valid = '0;
		cli_req = '0;
		hold_stall = 1'b0;
		hold_ret = 1'b0;
		adv = '0;
		reset_idle();
		write_then_read();
		credit_rotation();
		back_pressure();
		full_fifo();
		interleaved_reads();
		$display("summary: %0d errors", errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/mem_arb_pkg.sv
source/mem_arb_ifs.sv
source/mem_arb_ctl.sv
source/mem_req_mux.sv
source/mem_rd_tag_fifo.sv
source/mem_rd_return.sv
source/mem_arb_top.sv
tb/ltc_model.sv
tb/mem_arb_tb.sv
